// ==== dii_package.sv ====
package dii_package;

   // One word of a packet on a debug channel
   typedef struct packed {
      logic [15:0] data;
      logic        last;                 // Final word of the packet
   } dii_flit;

   // Third word of every packet
   typedef struct packed {
      logic [3:0]  pkt_type;
      logic [11:0] arg;                  // Register or memory address
   } dii_hdr;

   typedef union packed {
      logic [15:0] raw;
      dii_hdr      hdr;
   } dii_word;

   localparam logic [3:0] REG_READ  = 4'd0;
   localparam logic [3:0] REG_WRITE = 4'd1;
   localparam logic [3:0] MEM_READ  = 4'd2;
   localparam logic [3:0] MEM_WRITE = 4'd3;
   localparam logic [3:0] RESP      = 4'd4;
   localparam logic [3:0] RESP_ERR  = 4'd5;

   localparam logic [15:0] HOST_ID = 16'h0000;   // Responses go back here

endpackage

// ==== dii_channel.sv ====
`timescale 1ns/100ps

interface dii_channel import dii_package::*; ();

   dii_flit flit;
   logic    valid;
   logic    ready;

   modport sender (
      output flit,
      output valid,
      input  ready
   );

   modport receiver (
      input  flit,
      input  valid,
      output ready
   );

endinterface

// ==== osd_him.sv ====
`timescale 1ns/100ps

module osd_him #(
   parameter int MAX_PKT_LEN = 8
) (
   input  logic         clk,
   input  logic         rst_n,
   input  logic [15:0]  host_in_data,
   input  logic         host_in_valid,
   output logic         host_in_ready,
   output logic [15:0]  host_out_data,
   output logic         host_out_valid,
   input  logic         host_out_ready,
   dii_channel.sender   dii_out,
   dii_channel.receiver dii_in
);

   localparam int CW = $clog2(MAX_PKT_LEN + 1);
   localparam int IW = $clog2(MAX_PKT_LEN);

   logic [CW-1:0] in_cnt;               // Words left in the current frame
   logic          in_take;

   logic [15:0]   pkt_buf [MAX_PKT_LEN];
   logic [CW-1:0] buf_cnt;
   logic          buf_full;
   logic [IW-1:0] rd_ptr;
   logic          sending;
   logic          cnt_sent;             // Length word already out
   logic          out_take;

   assign host_in_ready = (in_cnt == '0) || !dii_out.valid || dii_out.ready;
   assign in_take       = host_in_valid && host_in_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_cnt        <= '0;
         dii_out.valid <= 1'b0;
      end else begin
         if (dii_out.ready)
            dii_out.valid <= 1'b0;
         if (in_take) begin
            if (in_cnt == '0) begin
               in_cnt <= host_in_data[CW-1:0];   // Length word
            end else begin
               in_cnt        <= in_cnt - 1'b1;
               dii_out.valid <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_take && in_cnt != '0) begin
         dii_out.flit.data <= host_in_data;
         dii_out.flit.last <= (in_cnt == CW'(1));
      end
   end

   // Egress collects a whole response before framing it
   assign buf_full       = (buf_cnt == CW'(MAX_PKT_LEN));
   assign dii_in.ready   = !sending;
   assign host_out_valid = sending;
   assign host_out_data  = cnt_sent ? pkt_buf[rd_ptr] : {{(16-CW){1'b0}}, buf_cnt};
   assign out_take       = host_out_valid && host_out_ready;

   always_ff @(posedge clk) begin
      if (dii_in.valid && dii_in.ready && !buf_full)
         pkt_buf[buf_cnt[IW-1:0]] <= dii_in.flit.data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         buf_cnt  <= '0;
         rd_ptr   <= '0;
         sending  <= 1'b0;
         cnt_sent <= 1'b0;
      end else if (sending) begin
         if (out_take) begin
            if (!cnt_sent) begin
               cnt_sent <= 1'b1;
            end else if (CW'(rd_ptr) + 1'b1 == buf_cnt) begin
               sending  <= 1'b0;
               cnt_sent <= 1'b0;
               rd_ptr   <= '0;
               buf_cnt  <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
      end else if (dii_in.valid) begin
         if (!buf_full)
            buf_cnt <= buf_cnt + 1'b1;
         sending <= dii_in.flit.last;
      end
   end

endmodule

// ==== osd_scm.sv ====
`timescale 1ns/100ps

module osd_scm import dii_package::*; #(
   parameter logic [15:0] SCM_ID    = 16'd1,
   parameter logic [15:0] SYSTEM_ID = 16'h5a3c
) (
   input  logic         clk,
   input  logic         rst_n,
   dii_channel.receiver dii_in,
   dii_channel.sender   dii_out,
   output logic         sys_rst,
   output logic         cpu_rst
);

   localparam logic [15:0] NUM_MOD = 16'd2;

   logic [2:0]  rx_cnt;                 // Request words seen, saturates at 4
   logic [15:0] src_q;
   dii_word     hdr_q;
   logic [15:0] data_q;
   logic        resp_active;
   logic [1:0]  resp_idx;
   logic [1:0]  ctrl;                   // Bit 0 system reset, bit 1 CPU reset
   logic        rd_ok;
   logic        wr_ok;
   logic [15:0] rd_data;
   dii_word     resp_hdr;
   logic        resp_last;
   logic        resp_fire;

   assign rd_ok = (rx_cnt >= 3'd3) && (hdr_q.hdr.pkt_type == REG_READ) &&
                  (hdr_q.hdr.arg <= 12'd2);
   assign wr_ok = (rx_cnt == 3'd4) && (hdr_q.hdr.pkt_type == REG_WRITE) &&
                  (hdr_q.hdr.arg == 12'd2);

   always_comb begin
      case (hdr_q.hdr.arg[1:0])
         2'd0:    rd_data = SYSTEM_ID;
         2'd1:    rd_data = NUM_MOD;
         default: rd_data = {14'd0, ctrl};
      endcase
   end

   always_comb begin
      resp_hdr.hdr.pkt_type = (rd_ok || wr_ok) ? RESP : RESP_ERR;
      resp_hdr.hdr.arg      = hdr_q.hdr.arg;
   end

   assign resp_last     = rd_ok ? (resp_idx == 2'd3) : (resp_idx == 2'd2);
   assign resp_fire     = dii_out.valid && dii_out.ready;
   assign dii_in.ready  = !resp_active;
   assign dii_out.valid = resp_active;

   always_comb begin
      dii_out.flit.last = resp_last;
      case (resp_idx)
         2'd0:    dii_out.flit.data = src_q;       // Back to the requester
         2'd1:    dii_out.flit.data = SCM_ID;
         2'd2:    dii_out.flit.data = resp_hdr.raw;
         default: dii_out.flit.data = rd_data;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_cnt      <= 3'd0;
         resp_active <= 1'b0;
         resp_idx    <= 2'd0;
         ctrl        <= 2'd0;
      end else if (resp_active) begin
         if (resp_fire) begin
            if (resp_idx == 2'd0 && wr_ok)
               ctrl <= data_q[1:0];
            if (resp_last) begin
               resp_active <= 1'b0;
               resp_idx    <= 2'd0;
               rx_cnt      <= 3'd0;
            end else begin
               resp_idx <= resp_idx + 2'd1;
            end
         end
      end else if (dii_in.valid) begin
         if (rx_cnt != 3'd4)
            rx_cnt <= rx_cnt + 3'd1;
         resp_active <= dii_in.flit.last;
      end
   end

   always_ff @(posedge clk) begin
      if (dii_in.valid && dii_in.ready) begin
         case (rx_cnt)
            3'd1:    src_q     <= dii_in.flit.data;
            3'd2:    hdr_q.raw <= dii_in.flit.data;
            3'd3:    data_q    <= dii_in.flit.data;
            default: ;
         endcase
      end
   end

   assign sys_rst = ctrl[0];
   assign cpu_rst = ctrl[1];

endmodule

// ==== osd_mam.sv ====
`timescale 1ns/100ps

module osd_mam import dii_package::*; #(
   parameter logic [15:0] MAM_ID         = 16'd2,
   parameter int          MEM_ADDR_WIDTH = 12
) (
   input  logic                      clk,
   input  logic                      rst_n,
   dii_channel.receiver              dii_in,
   dii_channel.sender                dii_out,
   output logic                      req_valid,
   input  logic                      req_ready,
   output logic                      req_rw,
   output logic [MEM_ADDR_WIDTH-1:0] req_addr,
   output logic [15:0]               write_data,
   input  logic                      read_valid,
   input  logic [15:0]               read_data
);

   localparam logic [1:0] S_RECV = 2'd0;
   localparam logic [1:0] S_REQ  = 2'd1;
   localparam logic [1:0] S_READ = 2'd2;
   localparam logic [1:0] S_RESP = 2'd3;

   logic [1:0]  state;
   logic [2:0]  rx_cnt;                 // Request words seen, saturates at 4
   logic [15:0] src_q;
   dii_word     hdr_q;
   logic [15:0] data_q;                 // Write data, later the read result
   logic [1:0]  resp_idx;
   logic        is_read;
   logic        is_write;
   logic        mem_ok;
   dii_word     resp_hdr;
   logic        resp_last;
   logic        resp_fire;

   assign is_read  = (rx_cnt >= 3'd3) && (hdr_q.hdr.pkt_type == MEM_READ);
   assign is_write = (rx_cnt == 3'd4) && (hdr_q.hdr.pkt_type == MEM_WRITE);
   assign mem_ok   = is_read || is_write;

   assign req_valid  = (state == S_REQ) && mem_ok;
   assign req_rw     = is_write;
   assign req_addr   = hdr_q.hdr.arg[MEM_ADDR_WIDTH-1:0];
   assign write_data = data_q;

   always_comb begin
      resp_hdr.hdr.pkt_type = mem_ok ? RESP : RESP_ERR;
      resp_hdr.hdr.arg      = hdr_q.hdr.arg;
   end

   assign resp_last     = is_read ? (resp_idx == 2'd3) : (resp_idx == 2'd2);
   assign resp_fire     = dii_out.valid && dii_out.ready;
   assign dii_in.ready  = (state == S_RECV);
   assign dii_out.valid = (state == S_RESP);

   always_comb begin
      dii_out.flit.last = resp_last;
      case (resp_idx)
         2'd0:    dii_out.flit.data = src_q;
         2'd1:    dii_out.flit.data = MAM_ID;
         2'd2:    dii_out.flit.data = resp_hdr.raw;
         default: dii_out.flit.data = data_q;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= S_RECV;
         rx_cnt   <= 3'd0;
         resp_idx <= 2'd0;
      end else begin
         case (state)
            S_RECV: begin
               if (dii_in.valid) begin
                  if (rx_cnt != 3'd4)
                     rx_cnt <= rx_cnt + 3'd1;
                  if (dii_in.flit.last)
                     state <= S_REQ;
               end
            end
            S_REQ: begin
               if (!mem_ok)
                  state <= S_RESP;                   // Error goes straight out
               else if (req_ready)
                  state <= is_write ? S_RESP : S_READ;
            end
            S_READ: begin
               if (read_valid)
                  state <= S_RESP;
            end
            default: begin
               if (resp_fire) begin
                  if (resp_last) begin
                     state    <= S_RECV;
                     rx_cnt   <= 3'd0;
                     resp_idx <= 2'd0;
                  end else begin
                     resp_idx <= resp_idx + 2'd1;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (dii_in.valid && dii_in.ready) begin
         case (rx_cnt)
            3'd1:    src_q     <= dii_in.flit.data;
            3'd2:    hdr_q.raw <= dii_in.flit.data;
            3'd3:    data_q    <= dii_in.flit.data;
            default: ;
         endcase
      end
      if (state == S_READ && read_valid)
         data_q <= read_data;
   end

endmodule

// ==== debug_ring.sv ====
`timescale 1ns/100ps

module debug_ring import dii_package::*; #(
   parameter logic [15:0] SCM_ID = 16'd1,
   parameter logic [15:0] MAM_ID = 16'd2
) (
   input  logic         clk,
   input  logic         rst_n,
   dii_channel.receiver host_in,
   dii_channel.sender   host_out,
   dii_channel.sender   scm_out,
   dii_channel.receiver scm_in,
   dii_channel.sender   mam_out,
   dii_channel.receiver mam_in
);

   localparam logic [1:0] SEL_SCM  = 2'd0;
   localparam logic [1:0] SEL_MAM  = 2'd1;
   localparam logic [1:0] SEL_DROP = 2'd2;

   logic       req_first;               // Next request flit is a destination word
   logic [1:0] req_sel_q;
   logic [1:0] req_sel;
   logic       req_take;

   logic       resp_busy;               // Response packet in progress
   logic       resp_sel_q;
   logic       rr_mam;                  // MAM wins the next tie
   logic       grant_mam;
   logic       out_free;
   logic       src_valid;
   dii_flit    src_flit;
   logic       resp_take;

   always_comb begin
      req_sel = req_sel_q;
      if (req_first) begin
         if (host_in.flit.data == SCM_ID)
            req_sel = SEL_SCM;
         else if (host_in.flit.data == MAM_ID)
            req_sel = SEL_MAM;
         else
            req_sel = SEL_DROP;
      end
   end

   always_comb begin
      case (req_sel)
         SEL_SCM: host_in.ready = !scm_out.valid || scm_out.ready;
         SEL_MAM: host_in.ready = !mam_out.valid || mam_out.ready;
         default: host_in.ready = 1'b1;           // Unknown destination is swallowed
      endcase
   end

   assign req_take = host_in.valid && host_in.ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_first     <= 1'b1;
         req_sel_q     <= SEL_DROP;
         scm_out.valid <= 1'b0;
         mam_out.valid <= 1'b0;
      end else begin
         if (scm_out.ready)
            scm_out.valid <= 1'b0;
         if (mam_out.ready)
            mam_out.valid <= 1'b0;
         if (req_take) begin
            req_first <= host_in.flit.last;
            req_sel_q <= req_sel;
            if (req_sel == SEL_SCM)
               scm_out.valid <= 1'b1;
            if (req_sel == SEL_MAM)
               mam_out.valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_take && req_sel == SEL_SCM)
         scm_out.flit <= host_in.flit;
      if (req_take && req_sel == SEL_MAM)
         mam_out.flit <= host_in.flit;
   end

   // Responses are merged a whole packet at a time
   always_comb begin
      if (resp_busy)
         grant_mam = resp_sel_q;
      else if (rr_mam)
         grant_mam = mam_in.valid || !scm_in.valid;
      else
         grant_mam = mam_in.valid && !scm_in.valid;
   end

   assign out_free     = !host_out.valid || host_out.ready;
   assign src_valid    = grant_mam ? mam_in.valid : scm_in.valid;
   assign src_flit     = grant_mam ? mam_in.flit : scm_in.flit;
   assign scm_in.ready = !grant_mam && out_free;
   assign mam_in.ready = grant_mam && out_free;
   assign resp_take    = src_valid && out_free;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         host_out.valid <= 1'b0;
         resp_busy      <= 1'b0;
         resp_sel_q     <= 1'b0;
         rr_mam         <= 1'b0;
      end else begin
         if (host_out.ready)
            host_out.valid <= 1'b0;
         if (resp_take) begin
            host_out.valid <= 1'b1;
            resp_busy      <= !src_flit.last;
            resp_sel_q     <= grant_mam;
            if (src_flit.last)
               rr_mam <= !grant_mam;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (resp_take)
         host_out.flit <= src_flit;
   end

endmodule

// ==== debug_system.sv ====
`timescale 1ns/100ps

module debug_system #(
   parameter logic [15:0] SCM_ID         = 16'd1,
   parameter logic [15:0] MAM_ID         = 16'd2,
   parameter logic [15:0] SYSTEM_ID      = 16'h5a3c,
   parameter int          MEM_ADDR_WIDTH = 12,
   parameter int          MAX_PKT_LEN    = 8
) (
   input  logic                      clk,
   input  logic                      rst_n,

   input  logic [15:0]               host_in_data,
   input  logic                      host_in_valid,
   output logic                      host_in_ready,
   output logic [15:0]               host_out_data,
   output logic                      host_out_valid,
   input  logic                      host_out_ready,

   output logic                      sys_rst,
   output logic                      cpu_rst,

   output logic                      req_valid,
   input  logic                      req_ready,
   output logic                      req_rw,
   output logic [MEM_ADDR_WIDTH-1:0] req_addr,
   output logic [15:0]               write_data,
   input  logic                      read_valid,
   input  logic [15:0]               read_data
);

   dii_channel him_req ();
   dii_channel him_resp ();
   dii_channel scm_req ();
   dii_channel scm_resp ();
   dii_channel mam_req ();
   dii_channel mam_resp ();

   osd_him #(.MAX_PKT_LEN(MAX_PKT_LEN))
   u_him (.*,
          .dii_out (him_req),
          .dii_in  (him_resp));

   debug_ring #(.SCM_ID(SCM_ID), .MAM_ID(MAM_ID))
   u_ring (.clk      (clk),
           .rst_n    (rst_n),
           .host_in  (him_req),
           .host_out (him_resp),
           .scm_out  (scm_req),
           .scm_in   (scm_resp),
           .mam_out  (mam_req),
           .mam_in   (mam_resp));

   osd_scm #(.SCM_ID(SCM_ID), .SYSTEM_ID(SYSTEM_ID))
   u_scm (.*,
          .dii_in  (scm_req),
          .dii_out (scm_resp));

   osd_mam #(.MAM_ID(MAM_ID), .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH))
   u_mam (.*,
          .dii_in  (mam_req),
          .dii_out (mam_resp));

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 2,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);                    // Release away from the active edge
      rst_n = 1'b1;
   end

endmodule

// ==== debug_system_asserts.sv ====
`timescale 1ns/100ps

module debug_system_asserts #(
   parameter int MEM_ADDR_WIDTH = 12
) (
   input logic                      clk,
   input logic                      rst_n,
   input logic                      host_out_valid,
   input logic                      host_out_ready,
   input logic [15:0]               host_out_data,
   input logic                      req_valid,
   input logic                      req_ready,
   input logic                      req_rw,
   input logic [MEM_ADDR_WIDTH-1:0] req_addr,
   input logic [15:0]               write_data,
   input logic                      read_valid
);

   logic rd_open;                        // Read issued, data not yet back

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rd_open <= 1'b0;
      else if (req_valid && req_ready && !req_rw)
         rd_open <= 1'b1;
      else if (read_valid)
         rd_open <= 1'b0;
   end

   host_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      host_out_valid && !host_out_ready |=> host_out_valid && $stable(host_out_data))
      else $error("host_out_valid dropped or data changed before accept");

   mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid && !req_ready |=> req_valid && $stable(req_addr) && $stable(req_rw)
                                  && $stable(write_data))
      else $error("memory request changed before req_ready");

   read_data_owed: assert property (@(posedge clk) disable iff (!rst_n)
      read_valid |-> rd_open)
      else $error("read_valid without an outstanding read");

endmodule

// ==== tb_debug_system.sv ====
`timescale 1ns/100ps

module tb_debug_system import dii_package::*; ();

   localparam logic [15:0] SCM_ID         = 16'd1;
   localparam logic [15:0] MAM_ID         = 16'd2;
   localparam logic [15:0] SYSTEM_ID      = 16'h5a3c;
   localparam int          MEM_ADDR_WIDTH = 12;
   localparam int          MAX_PKT_LEN    = 8;
   localparam int          TIMEOUT        = 2000;

   typedef struct packed {
      logic [15:0] dst;
      logic [15:0] src;
      dii_word     hdr;
      logic        has_data;
      logic [15:0] data;
   } resp_exp_t;

   logic clk, rst_n;
   logic [15:0] host_in_data, host_out_data, write_data, read_data;
   logic host_in_valid, host_in_ready, host_out_valid, host_out_ready;
   logic sys_rst, cpu_rst, req_valid, req_ready, req_rw, read_valid;
   logic [MEM_ADDR_WIDTH-1:0] req_addr;

   integer      seed = 32'h9c04;
   string       test_name = "reset";
   int          bp_level = 2;          // Chance in 8 that host_out_ready is low
   logic [1:0]  exp_ctrl = 2'd0;
   logic [15:0] exp_mem [int];
   logic [15:0] mem_store [int];
   resp_exp_t   scm_exp[$];
   resp_exp_t   mam_exp[$];
   logic [15:0] frame[$];
   logic [15:0] frame_cnt;
   bit          in_frame = 0;

   tb_clock_gen clock_gen_inst (.clk(clk), .rst_n(rst_n));

   debug_system #(.SCM_ID(SCM_ID), .MAM_ID(MAM_ID), .SYSTEM_ID(SYSTEM_ID),
                  .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH), .MAX_PKT_LEN(MAX_PKT_LEN))
   debug_system_inst (.*);

   bind debug_system debug_system_asserts #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_asserts (
      .clk(clk), .rst_n(rst_n), .host_out_valid(host_out_valid),
      .host_out_ready(host_out_ready), .host_out_data(host_out_data),
      .req_valid(req_valid), .req_ready(req_ready), .req_rw(req_rw),
      .req_addr(req_addr), .write_data(write_data), .read_valid(read_valid));

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   function automatic logic [15:0] fill_word(input int addr);
      logic [11:0] a;
      a = addr[11:0];
      return {a[3:0] ^ a[7:4] ^ 4'h9, a};
   endfunction

   task automatic abort(input string what);
      $display("[ERROR] %s: %s", test_name, what);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (act !== exp)
         abort($sformatf("%s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_hdr(input string name, input dii_word exp, input dii_word act);
      if (act.raw !== exp.raw)
         abort($sformatf("%s expected type %0d arg %h actual type %0d arg %h", name,
                         exp.hdr.pkt_type, exp.hdr.arg, act.hdr.pkt_type, act.hdr.arg));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort($sformatf("%s expected %b actual %b", name, exp, act));
   endtask

   task automatic check_resets(input logic exp_sys, input logic exp_cpu);
      if (sys_rst !== exp_sys || cpu_rst !== exp_cpu)
         abort($sformatf("reset outputs expected sys %b cpu %b actual sys %b cpu %b",
                         exp_sys, exp_cpu, sys_rst, cpu_rst));
   endtask

   task automatic send_word(input logic [15:0] w);
      int n;
      n = 0;
      @(negedge clk);
      host_in_valid = 1'b1;
      host_in_data  = w;
      while (!host_in_ready) begin
         n++;
         if (n > TIMEOUT)
            abort("host_in_ready stayed low");
         @(negedge clk);
      end
   endtask

   // Predicts the response, then sends the request frame
   task automatic send_req(input logic [15:0] dst, input logic [3:0] typ,
                           input logic [11:0] arg, input logic [15:0] data);
      dii_word   h;
      resp_exp_t r;
      bit        with_data;
      h.hdr.pkt_type = typ;
      h.hdr.arg      = arg;
      with_data      = (typ == REG_WRITE) || (typ == MEM_WRITE);
      r.dst          = HOST_ID;
      r.src          = dst;
      r.hdr.hdr.pkt_type = RESP_ERR;
      r.hdr.hdr.arg  = arg;
      r.has_data     = 1'b0;
      r.data         = 16'd0;
      if (dst == SCM_ID) begin
         if (typ == REG_READ && arg <= 12'd2) begin
            r.hdr.hdr.pkt_type = RESP;
            r.has_data = 1'b1;
            r.data = (arg == 12'd0) ? SYSTEM_ID : (arg == 12'd1) ? 16'd2 : {14'd0, exp_ctrl};
         end else if (typ == REG_WRITE && arg == 12'd2) begin
            r.hdr.hdr.pkt_type = RESP;
            exp_ctrl = data[1:0];
         end
         scm_exp.push_back(r);
      end else if (dst == MAM_ID) begin
         if (typ == MEM_READ) begin
            r.hdr.hdr.pkt_type = RESP;
            r.has_data = 1'b1;
            r.data = exp_mem.exists(int'(arg)) ? exp_mem[int'(arg)] : fill_word(int'(arg));
         end else if (typ == MEM_WRITE) begin
            r.hdr.hdr.pkt_type = RESP;
            exp_mem[int'(arg)] = data;
         end
         mam_exp.push_back(r);
      end
      send_word(with_data ? 16'd4 : 16'd3);
      send_word(dst);
      send_word(HOST_ID);
      send_word(h.raw);
      if (with_data)
         send_word(data);
      @(negedge clk);
      host_in_valid = 1'b0;
   endtask

   task automatic check_frame();
      resp_exp_t e;
      dii_word   h;
      if (frame.size() < 3)
         abort("response shorter than a packet header");
      if (frame[1] == SCM_ID && scm_exp.size() != 0)
         e = scm_exp.pop_front();
      else if (frame[1] == MAM_ID && mam_exp.size() != 0)
         e = mam_exp.pop_front();
      else
         abort($sformatf("response from source %h that nobody asked for", frame[1]));
      check_word("length word", e.has_data ? 16'd4 : 16'd3, frame_cnt);
      check_word("destination", e.dst, frame[0]);
      check_word("source", e.src, frame[1]);
      h.raw = frame[2];
      check_hdr("header", e.hdr, h);
      if (e.has_data)
         check_word("data", e.data, frame[3]);
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (scm_exp.size() != 0 || mam_exp.size() != 0 || in_frame) begin
         n++;
         if (n > TIMEOUT)
            abort("responses still outstanding after timeout");
         @(negedge clk);
      end
   endtask

   // Counts cycles with output on the host side
   task automatic count_stray(input int cycles, output int stray);
      stray = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (host_out_valid)
            stray++;
      end
   endtask

   // Host side receiver with random back-pressure
   initial begin
      logic [31:0] rnd;
      host_out_ready = 1'b0;
      forever begin
         @(negedge clk);
         rnd = next_rand();
         host_out_ready = (int'(rnd[2:0]) >= bp_level);
         if (rst_n && host_out_valid && host_out_ready) begin
            if (!in_frame) begin
               frame_cnt = host_out_data;
               frame.delete();
               in_frame = 1;
               if (frame_cnt == 16'd0 || frame_cnt > 16'(MAX_PKT_LEN))
                  abort($sformatf("length word %0d out of range", frame_cnt));
            end else begin
               frame.push_back(host_out_data);
               if (frame.size() == int'(frame_cnt)) begin
                  check_frame();
                  in_frame = 0;
               end
            end
         end
      end
   end

   // Memory with random req_ready and read latency
   initial begin
      logic [31:0]               rnd;
      bit                        rd_pending;
      int                        rd_wait;
      logic [MEM_ADDR_WIDTH-1:0] rd_addr;
      req_ready  = 1'b0;
      read_valid = 1'b0;
      read_data  = 16'd0;
      rd_pending = 0;
      forever begin
         @(negedge clk);
         read_valid = 1'b0;
         if (rd_pending) begin
            if (rd_wait == 0) begin
               read_valid = 1'b1;
               read_data  = mem_store.exists(int'(rd_addr)) ? mem_store[int'(rd_addr)]
                                                            : fill_word(int'(rd_addr));
               rd_pending = 0;
            end else begin
               rd_wait--;
            end
         end
         rnd = next_rand();
         req_ready = rnd[0];
         if (rst_n && req_valid && req_ready) begin
            if (req_rw) begin
               mem_store[int'(req_addr)] = write_data;
            end else begin
               rd_pending = 1;
               rd_addr    = req_addr;
               rd_wait    = int'(rnd[5:4]);
            end
         end
      end
   end

   initial begin
      logic [31:0] rnd;
      int          n;
      int          stray;
      host_in_valid = 1'b0;
      host_in_data  = 16'd0;
      n = 0;
      @(negedge clk);
      while (!rst_n) begin
         n++;
         if (n > TIMEOUT)
            abort("reset never released");
         @(negedge clk);
      end
      check_resets(1'b0, 1'b0);
      check_bit("host_in_ready", 1'b1, host_in_ready);
      check_bit("host_out_valid", 1'b0, host_out_valid);
      check_bit("req_valid", 1'b0, req_valid);

      test_name = "scm_id_read";
      send_req(SCM_ID, REG_READ, 12'd0, 16'd0);
      send_req(SCM_ID, REG_READ, 12'd1, 16'd0);
      wait_idle();

      test_name = "scm_ctrl";
      repeat (4) begin
         rnd = next_rand();
         send_req(SCM_ID, REG_WRITE, 12'd2, rnd[15:0]);
         wait_idle();
         check_resets(rnd[0], rnd[1]);
         send_req(SCM_ID, REG_READ, 12'd2, 16'd0);
         wait_idle();
      end

      test_name = "mem_random";
      repeat (40) begin
         rnd = next_rand();
         send_req(MAM_ID, rnd[8] ? MEM_WRITE : MEM_READ, {8'd0, rnd[3:0]}, rnd[31:16]);
      end
      wait_idle();

      test_name = "errors";
      rnd = next_rand();
      send_req(SCM_ID, REG_READ, 12'd3 + {4'd0, rnd[7:0]}, 16'd0);
      send_req(SCM_ID, REG_WRITE, 12'd0, rnd[31:16]);
      send_req(SCM_ID, 4'd6 + 4'(rnd[11:8] % 10), 12'd1, 16'd0);
      send_req(SCM_ID, MEM_READ, 12'd0, 16'd0);
      send_req(MAM_ID, REG_READ, 12'd5, 16'd0);
      send_req(MAM_ID, RESP, 12'd5, 16'd0);
      send_req({8'h01, rnd[23:16]}, MEM_WRITE, 12'd7, rnd[15:0]);   // Unknown destination
      send_req({8'h01, rnd[31:24]}, REG_READ, 12'd0, 16'd0);
      send_req(SCM_ID, REG_READ, 12'd0, 16'd0);
      wait_idle();
      check_resets(exp_ctrl[0], exp_ctrl[1]);

      test_name = "interleaved";
      bp_level = 5;
      repeat (60) begin
         rnd = next_rand();
         case (rnd[1:0])
            2'd0:    send_req(SCM_ID, REG_READ, {10'd0, rnd[3:2]}, 16'd0);
            2'd1:    send_req(SCM_ID, REG_WRITE, 12'd2, rnd[31:16]);
            2'd2:    send_req(MAM_ID, MEM_READ, {8'd0, rnd[7:4]}, 16'd0);
            default: send_req(MAM_ID, MEM_WRITE, {8'd0, rnd[7:4]}, rnd[31:16]);
         endcase
      end
      wait_idle();
      check_resets(exp_ctrl[0], exp_ctrl[1]);
      count_stray(40, stray);

      if (stray == 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         abort("host_out_valid raised after the last expected response");
      end
   end

endmodule

// ==== verilog.f ====
dii_package.sv
dii_channel.sv
osd_him.sv
osd_scm.sv
osd_mam.sv
debug_ring.sv
debug_system.sv
tb_clock_gen.sv
debug_system_asserts.sv
tb_debug_system.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_debug_system \
   -f verilog.f -Mdir obj_dir -o tb_debug_system

./obj_dir/tb_debug_system > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
